/* hw/core_bus_pkg.sv */
// Core load/store port widths and word types
`default_nettype none

package core_bus_pkg;

  // ********************************************************************
  // Port widths
  // ********************************************************************
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;  // One strobe per byte
  localparam int unsigned ATOP_WIDTH = 6;               // Atomic opcode

  // ********************************************************************
  // Word types
  // ********************************************************************
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;
  typedef logic [ATOP_WIDTH-1:0] atop_t;

endpackage

`default_nettype wire

/* hw/cluster_map_pkg.sv */
// Cluster memory map constants, destination enum and address views
`default_nettype none

package cluster_map_pkg;

  localparam int unsigned CLUSTER_ID_WIDTH = 6;
  localparam int unsigned REGION_WIDTH     = 12;  // Address bits 31:20

  // Region of cluster 0, each cluster owns four consecutive regions
  localparam logic [REGION_WIDTH-1:0] CLUSTER_REGION_BASE = 12'h100;
  localparam logic [REGION_WIDTH-1:0] TCDM_RW_OFS         = 12'd0;
  localparam logic [REGION_WIDTH-1:0] TCDM_TS_OFS         = 12'd1;  // Test-and-set alias
  localparam logic [REGION_WIDTH-1:0] DEM_PER_OFS         = 12'd2;  // Peripheral window

  typedef enum logic [1:0] {
    DEST_SH,   // Shared TCDM
    DEST_PE,   // Peripheral interconnect
    DEST_EXT   // Demux peripherals
  } dest_e;

  // Address seen as region, window select and offset
  typedef struct packed {
    logic [REGION_WIDTH-1:0] region;
    logic [4:0]              spare;
    logic                    ext_sel;  // Bit 14
    logic [13:0]             offset;
  } map_region_t;

  // Address seen as a pair of regions, RW and TS share the upper bits
  typedef struct packed {
    logic [REGION_WIDTH-2:0] region_pair;
    logic                    region_lsb;
    logic [19:0]             rest;
  } map_pair_t;

  typedef union packed {
    map_region_t win;
    map_pair_t   pair;
  } map_addr_u;

endpackage

`default_nettype wire

/* hw/pe_side_if.sv */
// Peripheral side signals shared by steering, PE FSM and response select
`timescale 1ns/100ps
`default_nettype none

interface pe_side_if;

  logic                 pe_req;   // Request towards the peripheral interconnect
  logic                 pe_gnt;   // Grant back to the core
  logic                 r_valid;  // Delayed PE response
  core_bus_pkg::data_t  r_rdata;
  logic                 r_opc;

  modport fsm (
    output pe_req, pe_gnt, r_valid, r_rdata, r_opc
  );

  modport steer (
    input pe_req, pe_gnt
  );

  modport resp (
    input r_valid, r_rdata, r_opc
  );

endinterface

`default_nettype wire

/* hw/demux_addr_decode.sv */
// Address decoder that maps a core address onto SH, PE or EXT
`timescale 1ns/100ps
`default_nettype none

module demux_addr_decode (
  input  core_bus_pkg::addr_t                          data_add_i,
  input  logic [cluster_map_pkg::CLUSTER_ID_WIDTH-1:0] cluster_id_i,
  output cluster_map_pkg::dest_e                       dest_o
);

  import cluster_map_pkg::*;

  logic [REGION_WIDTH-1:0] cluster_ofs;
  logic [REGION_WIDTH-1:0] tcdm_rw;
  logic [REGION_WIDTH-1:0] dem_per;
  map_addr_u               addr;
  logic                    sh_hit;
  logic                    per_hit;

  assign addr        = data_add_i;
  assign cluster_ofs = REGION_WIDTH'({cluster_id_i, 2'b00});  // Four regions per cluster

  assign tcdm_rw = CLUSTER_REGION_BASE + cluster_ofs + TCDM_RW_OFS;
  assign dem_per = CLUSTER_REGION_BASE + cluster_ofs + DEM_PER_OFS;

  // RW and TS share all region bits but the lowest
  assign sh_hit  = (addr.pair.region_pair == tcdm_rw[REGION_WIDTH-1:1]);
  assign per_hit = (addr.win.region == dem_per);

  always_comb
  begin
    if (sh_hit)
      dest_o = DEST_SH;
    else if (per_hit && addr.win.ext_sel)
      dest_o = DEST_EXT;
    else
      dest_o = DEST_PE;  // Cluster peripherals and rest of the map
  end

endmodule

`default_nettype wire

/* hw/demux_req_steer.sv */
// Request and grant steering per destination, L2 performance strobes
`timescale 1ns/100ps
`default_nettype none

module demux_req_steer (
  input  cluster_map_pkg::dest_e dest_i,
  input  logic                   data_req_i,
  input  logic                   data_wen_i,
  input  logic                   data_gnt_i_sh,
  input  logic                   data_gnt_i_ext,
  pe_side_if.steer               pe,
  output logic                   data_req_o_sh,
  output logic                   data_req_o_ext,
  output logic                   data_gnt_o,
  output logic                   perf_l2_ld_o,
  output logic                   perf_l2_st_o,
  output logic                   perf_l2_ld_cyc_o,
  output logic                   perf_l2_st_cyc_o
);

  import cluster_map_pkg::*;

  logic l2_req;  // Core request heading to PE or EXT
  logic l2_gnt;

  always_comb
  begin
    data_req_o_sh  = 1'b0;
    data_req_o_ext = 1'b0;
    l2_req         = 1'b0;
    l2_gnt         = 1'b0;
    case (dest_i)
      DEST_SH:
      begin
        data_req_o_sh = data_req_i;
      end
      DEST_EXT:
      begin
        data_req_o_ext = data_req_i;
        l2_req         = data_req_i;
        l2_gnt         = data_gnt_i_ext;
      end
      default:
      begin
        l2_req = data_req_i;  // PE request itself comes from the FSM
        l2_gnt = pe.pe_gnt;
      end
    endcase
  end

  assign data_gnt_o = (dest_i == DEST_SH) ? data_gnt_i_sh : l2_gnt;

  // ********************************************************************
  // L2 performance strobes
  // ********************************************************************
  assign perf_l2_ld_o     = l2_req & l2_gnt & data_wen_i;
  assign perf_l2_st_o     = l2_req & l2_gnt & ~data_wen_i;
  assign perf_l2_ld_cyc_o = l2_req & data_wen_i;   // Counts stalled cycles too
  assign perf_l2_st_cyc_o = l2_req & ~data_wen_i;

  always_comb
  begin
    if (!$isunknown(dest_i))
      assert ($onehot0({data_req_o_sh, data_req_o_ext, pe.pe_req}))
        else $error("more than one target request");
  end

endmodule

`default_nettype wire

/* hw/pe_txn_fsm.sv */
// Peripheral transaction FSM with one outstanding access
// Two-stage delay of the PE response
`timescale 1ns/100ps
`default_nettype none

module pe_txn_fsm (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   data_req_i,
  input  cluster_map_pkg::dest_e dest_i,
  input  logic                   data_gnt_i_pe,
  input  logic                   data_r_valid_i_pe,
  input  logic                   data_r_opc_i_pe,
  input  core_bus_pkg::data_t    data_r_rdata_i_pe,
  pe_side_if.fsm                 pe
);

  import core_bus_pkg::*;
  import cluster_map_pkg::*;

  typedef enum logic [1:0] {TXN_IDLE, TXN_PENDING, TXN_GRANTED} txn_state_e;

  txn_state_e state_q, state_d;
  logic       rsp_valid_q;  // First delay stage
  data_t      rsp_rdata_q;
  logic       rsp_opc_q;

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= TXN_IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d   = state_q;
    pe.pe_req = 1'b0;
    pe.pe_gnt = 1'b0;
    case (state_q)
      TXN_IDLE:
      begin
        if (data_req_i && (dest_i == DEST_PE))
        begin
          pe.pe_req = 1'b1;
          if (data_gnt_i_pe)
            state_d = TXN_PENDING;  // Accepted by the interconnect
        end
      end
      TXN_PENDING:
      begin
        if (data_r_valid_i_pe)
          state_d = TXN_GRANTED;
      end
      TXN_GRANTED:
      begin
        pe.pe_gnt = 1'b1;  // Core sees the grant only now
        state_d   = TXN_IDLE;
      end
      default:
      begin
        state_d = TXN_IDLE;
      end
    endcase
  end

  // ********************************************************************
  // Response delay, payload captured only with a valid response
  // ********************************************************************
  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rsp_valid_q <= 1'b0;
      rsp_rdata_q <= '0;
      rsp_opc_q   <= 1'b0;
      pe.r_valid  <= 1'b0;
      pe.r_rdata  <= '0;
      pe.r_opc    <= 1'b0;
    end
    else
    begin
      rsp_valid_q <= data_r_valid_i_pe;
      pe.r_valid  <= rsp_valid_q;
      if (data_r_valid_i_pe)
      begin
        rsp_rdata_q <= data_r_rdata_i_pe;
        rsp_opc_q   <= data_r_opc_i_pe;
      end
      if (rsp_valid_q)
      begin
        pe.r_rdata <= rsp_rdata_q;
        pe.r_opc   <= rsp_opc_q;
      end
    end
  end

  // Core grant comes one cycle after the response, data one cycle later
  a_gnt_after_rsp: assert property (@(posedge clk) disable iff (!rst_ni)
    pe.pe_gnt |-> $past(data_r_valid_i_pe));
  a_rsp_after_gnt: assert property (@(posedge clk) disable iff (!rst_ni)
    pe.pe_gnt |=> pe.r_valid);

endmodule

`default_nettype wire

/* hw/demux_resp_select.sv */
// Registered response destination and response mux
`timescale 1ns/100ps
`default_nettype none

module demux_resp_select (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic                   data_req_i,
  input  cluster_map_pkg::dest_e dest_i,
  pe_side_if.resp                pe,
  input  logic                   sh_r_valid_i,
  input  core_bus_pkg::data_t    sh_r_rdata_i,
  input  logic                   ext_r_valid_i,
  input  core_bus_pkg::data_t    ext_r_rdata_i,
  input  logic                   ext_r_opc_i,
  output logic                   data_r_valid_o,
  output core_bus_pkg::data_t    data_r_rdata_o,
  output logic                   data_r_opc_o
);

  import cluster_map_pkg::*;

  dest_e resp_dest_q;  // Target of the last request

  always_ff @(posedge clk, negedge rst_ni)
  begin
    if (!rst_ni)
      resp_dest_q <= DEST_SH;
    else if (data_req_i)
      resp_dest_q <= dest_i;
  end

  always_comb
  begin
    case (resp_dest_q)
      DEST_SH:
      begin
        data_r_valid_o = sh_r_valid_i;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;  // TCDM never flags an error
      end
      DEST_PE:
      begin
        data_r_valid_o = pe.r_valid;
        data_r_rdata_o = pe.r_rdata;
        data_r_opc_o   = pe.r_opc;
      end
      DEST_EXT:
      begin
        data_r_valid_o = ext_r_valid_i;
        data_r_rdata_o = ext_r_rdata_i;
        data_r_opc_o   = ext_r_opc_i;
      end
      default:
      begin
        data_r_valid_o = 1'b0;
        data_r_rdata_o = sh_r_rdata_i;
        data_r_opc_o   = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/core_demux_top.sv */
// Core data demultiplexer top: decode, steering, PE FSM, response select
`timescale 1ns/100ps
`default_nettype none

module core_demux_top (
  input  logic                                         clk,
  input  logic                                         rst_ni,
  input  logic [cluster_map_pkg::CLUSTER_ID_WIDTH-1:0] cluster_id_i,

  // Core request
  input  logic                  data_req_i,
  input  core_bus_pkg::addr_t   data_add_i,
  input  logic                  data_wen_i,
  input  core_bus_pkg::atop_t   data_atop_i,
  input  core_bus_pkg::data_t   data_wdata_i,
  input  core_bus_pkg::be_t     data_be_i,
  output logic                  data_gnt_o,
  // Core response
  output logic                  data_r_valid_o,
  output core_bus_pkg::data_t   data_r_rdata_o,
  output logic                  data_r_opc_o,

  // Shared TCDM
  output logic                  data_req_sh_o,
  output core_bus_pkg::addr_t   data_add_sh_o,
  output logic                  data_wen_sh_o,
  output core_bus_pkg::atop_t   data_atop_sh_o,
  output core_bus_pkg::data_t   data_wdata_sh_o,
  output core_bus_pkg::be_t     data_be_sh_o,
  input  logic                  data_gnt_sh_i,
  input  logic                  data_r_valid_sh_i,
  input  core_bus_pkg::data_t   data_r_rdata_sh_i,

  // Demux peripherals, no atomics
  output logic                  data_req_ext_o,
  output core_bus_pkg::addr_t   data_add_ext_o,
  output logic                  data_wen_ext_o,
  output core_bus_pkg::data_t   data_wdata_ext_o,
  output core_bus_pkg::be_t     data_be_ext_o,
  input  logic                  data_gnt_ext_i,
  input  logic                  data_r_valid_ext_i,
  input  core_bus_pkg::data_t   data_r_rdata_ext_i,
  input  logic                  data_r_opc_ext_i,

  // Peripheral interconnect
  output logic                  data_req_pe_o,
  output core_bus_pkg::addr_t   data_add_pe_o,
  output logic                  data_wen_pe_o,
  output core_bus_pkg::atop_t   data_atop_pe_o,
  output core_bus_pkg::data_t   data_wdata_pe_o,
  output core_bus_pkg::be_t     data_be_pe_o,
  input  logic                  data_gnt_pe_i,
  input  logic                  data_r_valid_pe_i,
  input  logic                  data_r_opc_pe_i,
  input  core_bus_pkg::data_t   data_r_rdata_pe_i,

  // L2 performance strobes
  output logic                  perf_l2_ld_o,
  output logic                  perf_l2_st_o,
  output logic                  perf_l2_ld_cyc_o,
  output logic                  perf_l2_st_cyc_o
);

  import cluster_map_pkg::*;

  dest_e     dest;
  pe_side_if pe_bus ();

  // ********************************************************************
  // Payload fan-out, only the requests are steered
  // ********************************************************************
  assign data_add_sh_o   = data_add_i;
  assign data_wen_sh_o   = data_wen_i;
  assign data_atop_sh_o  = data_atop_i;
  assign data_wdata_sh_o = data_wdata_i;
  assign data_be_sh_o    = data_be_i;

  assign data_add_ext_o   = data_add_i;
  assign data_wen_ext_o   = data_wen_i;
  assign data_wdata_ext_o = data_wdata_i;
  assign data_be_ext_o    = data_be_i;

  assign data_add_pe_o   = data_add_i;
  assign data_wen_pe_o   = data_wen_i;
  assign data_atop_pe_o  = data_atop_i;
  assign data_wdata_pe_o = data_wdata_i;
  assign data_be_pe_o    = data_be_i;
  assign data_req_pe_o   = pe_bus.pe_req;  // PE request straight from the FSM

  demux_addr_decode u_decode (
    .data_add_i   (data_add_i),
    .cluster_id_i (cluster_id_i),
    .dest_o       (dest)
  );

  demux_req_steer u_steer (
    .dest_i           (dest),
    .data_req_i       (data_req_i),
    .data_wen_i       (data_wen_i),
    .data_gnt_i_sh    (data_gnt_sh_i),
    .data_gnt_i_ext   (data_gnt_ext_i),
    .pe               (pe_bus.steer),
    .data_req_o_sh    (data_req_sh_o),
    .data_req_o_ext   (data_req_ext_o),
    .data_gnt_o       (data_gnt_o),
    .perf_l2_ld_o     (perf_l2_ld_o),
    .perf_l2_st_o     (perf_l2_st_o),
    .perf_l2_ld_cyc_o (perf_l2_ld_cyc_o),
    .perf_l2_st_cyc_o (perf_l2_st_cyc_o)
  );

  pe_txn_fsm u_pe_fsm (
    .clk               (clk),
    .rst_ni            (rst_ni),
    .data_req_i        (data_req_i),
    .dest_i            (dest),
    .data_gnt_i_pe     (data_gnt_pe_i),
    .data_r_valid_i_pe (data_r_valid_pe_i),
    .data_r_opc_i_pe   (data_r_opc_pe_i),
    .data_r_rdata_i_pe (data_r_rdata_pe_i),
    .pe                (pe_bus.fsm)
  );

  demux_resp_select u_resp (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .data_req_i     (data_req_i),
    .dest_i         (dest),
    .pe             (pe_bus.resp),
    .sh_r_valid_i   (data_r_valid_sh_i),
    .sh_r_rdata_i   (data_r_rdata_sh_i),
    .ext_r_valid_i  (data_r_valid_ext_i),
    .ext_r_rdata_i  (data_r_rdata_ext_i),
    .ext_r_opc_i    (data_r_opc_ext_i),
    .data_r_valid_o (data_r_valid_o),
    .data_r_rdata_o (data_r_rdata_o),
    .data_r_opc_o   (data_r_opc_o)
  );

endmodule

`default_nettype wire

/* verification/tb_core_demux.sv */
// Directed testbench for the core data demultiplexer
// Clock, reset, LFSR stimulus, test tasks, timeout and summary
`timescale 1ns/100ps
`default_nettype none

module tb_core_demux;

  localparam int TIMEOUT_CYCLES = 2000;  // Tests take about 70 cycles
  localparam logic [31:0] LFSR_SEED = 32'd94115;

  logic        clk = 1'b0;
  logic        rst_ni;
  logic [5:0]  cluster_id_i;
  logic        data_req_i;
  logic [31:0] data_add_i;
  logic        data_wen_i;
  logic [5:0]  data_atop_i;
  logic [31:0] data_wdata_i;
  logic [3:0]  data_be_i;
  logic        data_gnt_o;
  logic        data_r_valid_o;
  logic [31:0] data_r_rdata_o;
  logic        data_r_opc_o;
  logic        data_req_sh_o;
  logic [31:0] data_add_sh_o;
  logic        data_wen_sh_o;
  logic [5:0]  data_atop_sh_o;
  logic [31:0] data_wdata_sh_o;
  logic [3:0]  data_be_sh_o;
  logic        data_gnt_sh_i;
  logic        data_r_valid_sh_i;
  logic [31:0] data_r_rdata_sh_i;
  logic        data_req_ext_o;
  logic [31:0] data_add_ext_o;
  logic        data_wen_ext_o;
  logic [31:0] data_wdata_ext_o;
  logic [3:0]  data_be_ext_o;
  logic        data_gnt_ext_i;
  logic        data_r_valid_ext_i;
  logic [31:0] data_r_rdata_ext_i;
  logic        data_r_opc_ext_i;
  logic        data_req_pe_o;
  logic [31:0] data_add_pe_o;
  logic        data_wen_pe_o;
  logic [5:0]  data_atop_pe_o;
  logic [31:0] data_wdata_pe_o;
  logic [3:0]  data_be_pe_o;
  logic        data_gnt_pe_i;
  logic        data_r_valid_pe_i;
  logic        data_r_opc_pe_i;
  logic [31:0] data_r_rdata_pe_i;
  logic        perf_l2_ld_o;
  logic        perf_l2_st_o;
  logic        perf_l2_ld_cyc_o;
  logic        perf_l2_st_cyc_o;

  logic [2:0]  req_vec;   // {SH, PE, EXT}
  logic [3:0]  perf_vec;  // {ld, st, ld_cyc, st_cyc}
  int          errors = 0;
  int          tests = 0;
  int          cycles = 0;
  logic [31:0] lfsr = LFSR_SEED;

  assign req_vec  = {data_req_sh_o, data_req_pe_o, data_req_ext_o};
  assign perf_vec = {perf_l2_ld_o, perf_l2_st_o, perf_l2_ld_cyc_o, perf_l2_st_cyc_o};

  core_demux_top uut (.*);

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // *********************************************************************
  // Helpers
  // *********************************************************************
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [11:0] cluster_base(input logic [5:0] cid);
    return 12'h100 + {4'b0000, cid, 2'b00};
  endfunction

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before)
      $display("test %s passed", name);
    else
      $display("test %s failed with %0d errors", name, errors - errs_before);
  endtask

  task automatic drive_req(input logic [31:0] addr, input logic [5:0] cid, input logic wen);
    logic [31:0] r;
    rand_bits(32, r);
    data_wdata_i <= r;
    rand_bits(10, r);
    data_be_i    <= r[3:0];
    data_atop_i  <= r[9:4];
    cluster_id_i <= cid;
    data_add_i   <= addr;
    data_wen_i   <= wen;
    data_req_i   <= 1'b1;
  endtask

  // Address, write enable and payload reach every target port unchanged
  task automatic check_fanout;
    if (data_add_sh_o !== data_add_i)
      mismatch("data_add_sh_o", data_add_sh_o, data_add_i);
    if (data_add_ext_o !== data_add_i)
      mismatch("data_add_ext_o", data_add_ext_o, data_add_i);
    if (data_add_pe_o !== data_add_i)
      mismatch("data_add_pe_o", data_add_pe_o, data_add_i);
    if (data_wen_sh_o !== data_wen_i)
      mismatch("data_wen_sh_o", 32'(data_wen_sh_o), 32'(data_wen_i));
    if (data_wen_ext_o !== data_wen_i)
      mismatch("data_wen_ext_o", 32'(data_wen_ext_o), 32'(data_wen_i));
    if (data_wen_pe_o !== data_wen_i)
      mismatch("data_wen_pe_o", 32'(data_wen_pe_o), 32'(data_wen_i));
    if (data_atop_sh_o !== data_atop_i)
      mismatch("data_atop_sh_o", 32'(data_atop_sh_o), 32'(data_atop_i));
    if (data_atop_pe_o !== data_atop_i)
      mismatch("data_atop_pe_o", 32'(data_atop_pe_o), 32'(data_atop_i));
    if (data_wdata_sh_o !== data_wdata_i)
      mismatch("data_wdata_sh_o", data_wdata_sh_o, data_wdata_i);
    if (data_wdata_ext_o !== data_wdata_i)
      mismatch("data_wdata_ext_o", data_wdata_ext_o, data_wdata_i);
    if (data_wdata_pe_o !== data_wdata_i)
      mismatch("data_wdata_pe_o", data_wdata_pe_o, data_wdata_i);
    if (data_be_sh_o !== data_be_i)
      mismatch("data_be_sh_o", 32'(data_be_sh_o), 32'(data_be_i));
    if (data_be_ext_o !== data_be_i)
      mismatch("data_be_ext_o", 32'(data_be_ext_o), 32'(data_be_i));
    if (data_be_pe_o !== data_be_i)
      mismatch("data_be_pe_o", 32'(data_be_pe_o), 32'(data_be_i));
  endtask

  // *********************************************************************
  // Tests
  // *********************************************************************
  task automatic test_reset;
    int          errs;
    logic [31:0] r;
    errs = errors;
    rand_bits(32, r);
    repeat (8)
    begin
      @(posedge clk);
      data_r_valid_pe_i <= 1'b1;  // Held off by the delay stages in reset
      data_r_rdata_pe_i <= r;
      @(negedge clk);
      if (data_req_pe_o !== 1'b0) mismatch("data_req_pe_o", 32'(data_req_pe_o), 32'h0);
      if (data_r_valid_o !== 1'b0) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h0);
    end
    @(posedge clk);
    rst_ni            <= 1'b1;
    data_r_valid_pe_i <= 1'b0;
    @(negedge clk);
    if (data_req_pe_o !== 1'b0) mismatch("data_req_pe_o", 32'(data_req_pe_o), 32'h0);
    if (data_r_valid_o !== 1'b0) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h0);
    @(posedge clk);
    data_r_valid_sh_i  <= 1'b1;
    data_r_rdata_sh_i  <= r;
    data_r_valid_ext_i <= 1'b1;  // Must not be selected
    data_r_rdata_ext_i <= ~r;
    @(negedge clk);
    if (data_r_valid_o !== 1'b1) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h1);
    if (data_r_rdata_o !== r) mismatch("data_r_rdata_o", data_r_rdata_o, r);
    @(posedge clk);
    data_r_valid_sh_i  <= 1'b0;
    data_r_valid_ext_i <= 1'b0;
    end_test("reset", errs);
  endtask

  task automatic test_sh_routing;
    int          errs;
    logic [31:0] r;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [5:0]  cid;
    errs = errors;
    rand_bits(6, r);
    cid = r[5:0];
    rand_bits(21, r);  // RW or TS alias, then offset
    addr = {cluster_base(cid) + {11'b0, r[20]}, r[19:0]};
    rand_bits(32, rdata);
    @(posedge clk);
    drive_req(addr, cid, 1'b1);
    data_gnt_sh_i <= 1'b0;
    @(negedge clk);
    if (req_vec !== 3'b100) mismatch("req {sh,pe,ext}", 32'(req_vec), 32'h4);
    if (data_gnt_o !== 1'b0) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h0);
    check_fanout();
    @(posedge clk);
    data_gnt_sh_i <= 1'b1;
    @(negedge clk);
    if (data_gnt_o !== 1'b1) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h1);
    @(posedge clk);
    data_req_i        <= 1'b0;
    data_gnt_sh_i     <= 1'b0;
    data_r_valid_sh_i <= 1'b1;
    data_r_rdata_sh_i <= rdata;
    data_r_opc_ext_i  <= 1'b1;  // Must not leak into the SH response
    @(negedge clk);
    if (req_vec !== 3'b000) mismatch("req {sh,pe,ext}", 32'(req_vec), 32'h0);
    if (data_r_valid_o !== 1'b1) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h1);
    if (data_r_rdata_o !== rdata) mismatch("data_r_rdata_o", data_r_rdata_o, rdata);
    if (data_r_opc_o !== 1'b0) mismatch("data_r_opc_o", 32'(data_r_opc_o), 32'h0);
    @(posedge clk);
    data_r_valid_sh_i <= 1'b0;
    data_r_opc_ext_i  <= 1'b0;
    end_test("sh_routing", errs);
  endtask

  task automatic test_ext_routing;
    int          errs;
    logic [31:0] r;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic [5:0]  cid;
    errs = errors;
    rand_bits(6, r);
    cid = r[5:0];
    rand_bits(19, r);
    addr = {cluster_base(cid) + 12'd2, r[18:14], 1'b1, r[13:0]};
    rand_bits(32, rdata);
    @(posedge clk);
    drive_req(addr, cid, 1'b0);
    data_gnt_ext_i <= 1'b1;
    @(negedge clk);
    if (req_vec !== 3'b001) mismatch("req {sh,pe,ext}", 32'(req_vec), 32'h1);
    if (data_gnt_o !== 1'b1) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h1);
    check_fanout();
    rand_bits(1, r);
    @(posedge clk);
    data_req_i         <= 1'b0;
    data_gnt_ext_i     <= 1'b0;
    data_r_valid_ext_i <= 1'b1;
    data_r_rdata_ext_i <= rdata;
    data_r_opc_ext_i   <= r[0];
    @(negedge clk);
    if (data_r_valid_o !== 1'b1) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h1);
    if (data_r_rdata_o !== rdata) mismatch("data_r_rdata_o", data_r_rdata_o, rdata);
    if (data_r_opc_o !== r[0]) mismatch("data_r_opc_o", 32'(data_r_opc_o), 32'(r[0]));
    @(posedge clk);
    data_r_valid_ext_i <= 1'b0;
    data_r_opc_ext_i   <= 1'b0;
    end_test("ext_routing", errs);
  endtask

  // One PE access, stalled, accepted, then answered
  task automatic pe_access(input logic [31:0] addr, input logic [5:0] cid);
    logic [31:0] rdata;
    logic [31:0] r;
    rand_bits(32, rdata);
    rand_bits(1, r);
    @(posedge clk);
    drive_req(addr, cid, 1'b1);
    data_gnt_pe_i <= 1'b0;
    @(negedge clk);
    check_fanout();
    @(posedge clk);
    repeat (3)
    begin
      @(negedge clk);
      if (req_vec !== 3'b010) mismatch("req {sh,pe,ext}", 32'(req_vec), 32'h2);
      if (data_gnt_o !== 1'b0) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h0);
      @(posedge clk);
    end
    data_gnt_pe_i <= 1'b1;
    @(negedge clk);
    if (data_req_pe_o !== 1'b1) mismatch("data_req_pe_o", 32'(data_req_pe_o), 32'h1);
    @(posedge clk);
    data_gnt_pe_i <= 1'b0;
    @(negedge clk);
    if (data_req_pe_o !== 1'b0) mismatch("data_req_pe_o", 32'(data_req_pe_o), 32'h0);
    if (data_gnt_o !== 1'b0) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h0);
    @(posedge clk);
    data_r_valid_pe_i <= 1'b1;
    data_r_rdata_pe_i <= rdata;
    data_r_opc_pe_i   <= r[0];
    @(negedge clk);
    if (data_gnt_o !== 1'b0) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h0);
    @(posedge clk);
    data_r_valid_pe_i <= 1'b0;
    data_r_rdata_pe_i <= ~rdata;  // Payload outside the pulse is ignored
    data_r_opc_pe_i   <= ~r[0];
    @(negedge clk);
    if (data_gnt_o !== 1'b1) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h1);
    if (data_r_valid_o !== 1'b0) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h0);
    @(posedge clk);
    data_req_i <= 1'b0;
    @(negedge clk);
    if (data_gnt_o !== 1'b0) mismatch("data_gnt_o", 32'(data_gnt_o), 32'h0);
    if (data_r_valid_o !== 1'b1) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h1);
    if (data_r_rdata_o !== rdata) mismatch("data_r_rdata_o", data_r_rdata_o, rdata);
    if (data_r_opc_o !== r[0]) mismatch("data_r_opc_o", 32'(data_r_opc_o), 32'(r[0]));
    @(posedge clk);
    @(negedge clk);
    if (data_r_valid_o !== 1'b0) mismatch("data_r_valid_o", 32'(data_r_valid_o), 32'h0);
  endtask

  task automatic test_pe_txn;
    int          errs;
    logic [31:0] r;
    logic [5:0]  cid;
    errs = errors;
    rand_bits(6, r);
    cid = r[5:0];
    rand_bits(19, r);
    pe_access({cluster_base(cid) + 12'd2, r[18:14], 1'b0, r[13:0]}, cid);
    rand_bits(28, r);
    pe_access({4'h8, r[27:0]}, cid);  // Outside every cluster region
    end_test("pe_txn", errs);
  endtask

  task automatic test_cluster_map;
    int          errs;
    logic [31:0] r;
    logic [31:0] addr;
    logic [5:0]  cid_a;
    logic [5:0]  cid_b;
    errs = errors;
    rand_bits(12, r);
    cid_a = r[5:0];
    cid_b = (r[11:6] == r[5:0]) ? ~r[5:0] : r[11:6];
    rand_bits(20, r);
    addr = {cluster_base(cid_a), r[19:0]};
    @(posedge clk);
    drive_req(addr, cid_a, 1'b1);
    @(negedge clk);
    if (req_vec !== 3'b100) mismatch("req {sh,pe,ext}", 32'(req_vec), 32'h4);
    @(posedge clk);
    cluster_id_i <= cid_b;
    @(negedge clk);
    if (req_vec !== 3'b010) mismatch("req {sh,pe,ext}", 32'(req_vec), 32'h2);
    @(posedge clk);
    data_req_i <= 1'b0;
    end_test("cluster_map", errs);
  endtask

  task automatic perf_access(input logic wen);
    logic [31:0] r;
    logic [5:0]  cid;
    rand_bits(20, r);
    cid = r[19:14];
    @(posedge clk);
    drive_req({cluster_base(cid) + 12'd2, 5'b0, 1'b1, r[13:0]}, cid, wen);
    data_gnt_ext_i <= 1'b0;
    @(negedge clk);
    if (perf_vec !== {2'b00, wen, ~wen})
      mismatch("perf {ld,st,ld_cyc,st_cyc}", 32'(perf_vec), 32'({2'b00, wen, ~wen}));
    @(posedge clk);
    data_gnt_ext_i <= 1'b1;
    @(negedge clk);
    if (perf_vec !== {wen, ~wen, wen, ~wen})
      mismatch("perf {ld,st,ld_cyc,st_cyc}", 32'(perf_vec), 32'({wen, ~wen, wen, ~wen}));
    @(posedge clk);
    data_req_i     <= 1'b0;
    data_gnt_ext_i <= 1'b0;
  endtask

  task automatic test_perf;
    int          errs;
    logic [31:0] r;
    errs = errors;
    perf_access(1'b1);  // Load
    perf_access(1'b0);  // Store
    rand_bits(26, r);
    @(posedge clk);
    drive_req({cluster_base(r[25:20]), r[19:0]}, r[25:20], 1'b1);
    data_gnt_sh_i <= 1'b1;
    @(negedge clk);
    if (perf_vec !== 4'b0000) mismatch("perf {ld,st,ld_cyc,st_cyc}", 32'(perf_vec), 32'h0);
    @(posedge clk);
    data_req_i    <= 1'b0;
    data_gnt_sh_i <= 1'b0;
    end_test("perf", errs);
  endtask

  // *********************************************************************
  // Sequence
  // *********************************************************************
  initial
  begin
    rst_ni             <= 1'b0;
    cluster_id_i       <= '0;
    data_req_i         <= 1'b0;
    data_add_i         <= '0;
    data_wen_i         <= 1'b1;
    data_atop_i        <= '0;
    data_wdata_i       <= '0;
    data_be_i          <= 4'hf;
    data_gnt_sh_i      <= 1'b0;
    data_r_valid_sh_i  <= 1'b0;
    data_r_rdata_sh_i  <= '0;
    data_gnt_ext_i     <= 1'b0;
    data_r_valid_ext_i <= 1'b0;
    data_r_rdata_ext_i <= '0;
    data_r_opc_ext_i   <= 1'b0;
    data_gnt_pe_i      <= 1'b0;
    data_r_valid_pe_i  <= 1'b0;
    data_r_opc_pe_i    <= 1'b0;
    data_r_rdata_pe_i  <= '0;
    test_reset();
    test_sh_routing();
    test_ext_routing();
    test_pe_txn();
    test_cluster_map();
    test_perf();
    @(posedge clk);
    $display("Summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/core_bus_pkg.sv
hw/cluster_map_pkg.sv
hw/pe_side_if.sv
hw/demux_addr_decode.sv
hw/demux_req_steer.sv
hw/pe_txn_fsm.sv
hw/demux_resp_select.sv
hw/core_demux_top.sv
verification/tb_core_demux.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core demux testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_core_demux -o tb_core_demux
out=$(./obj_dir/tb_core_demux)
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
  exit 0
else
  exit 1
fi
